//--- hw/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    typedef logic [10:0] ee_addr_t;   // byte address of a 24C16 (2 KB)
    typedef logic [7:0]  ee_data_t;
    typedef logic [4:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // top nibble of the control byte
    localparam logic [3:0] DEV_TYPE = 4'b1010;

    // CLK cycles per quarter of an SCL period
    localparam int SCL_PHASE_CYCLES = 2;

    localparam apb_addr_t REG_CTRL   = 5'h00;
    localparam apb_addr_t REG_ADDR   = 5'h04;
    localparam apb_addr_t REG_WDATA  = 5'h08;
    localparam apb_addr_t REG_STATUS = 5'h0C;
    localparam apb_addr_t REG_RDATA  = 5'h10;

    typedef enum logic [1:0] {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } bit_cmd_t;

    typedef enum logic [3:0] {
        IDLE, START, CTRL_W, ADDR, DATA_W, RESTART, CTRL_R, DATA_R, STOP
    } seq_state_t;

endpackage

`default_nettype wire

//--- hw/i2c_bit_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_ctrl (
    input  wire logic                 CLK,
    input  wire logic                 RESET,
    input  wire eeprom_pkg::bit_cmd_t cmd,
    input  wire logic                 cmd_valid,
    input  wire logic                 tx_bit,
    output logic                      cmd_done,
    output logic                      rx_bit,
    output logic                      scl,
    output logic                      sda_drive_low,
    input  wire logic                 sda_in
);
    import eeprom_pkg::*;

    logic                                  active;
    bit_cmd_t                              cmd_q;
    logic                                  tx_q;
    logic [$clog2(SCL_PHASE_CYCLES+1)-1:0] div_cnt;
    logic [1:0]                            phase;      // quarter of the SCL period
    logic                                  phase_end;
    logic                                  scl_c;
    logic                                  sda_low_c;
    logic                                  scl_rest;   // levels held between commands
    logic                                  sda_low_rest;

    assign phase_end = (div_cnt == SCL_PHASE_CYCLES - 1);
    assign cmd_done = active && (phase == 2'd3) && phase_end;

    // scl high in the middle two quarters
    always_comb begin
        scl_c = (phase == 2'd1) || (phase == 2'd2);
        case (cmd_q)
            CMD_START: sda_low_c = phase[1];   // sda falls with scl high
            CMD_STOP: begin
                scl_c     = (phase != 2'd0);
                sda_low_c = !phase[1];          // sda rises with scl high
            end
            CMD_WRITE: sda_low_c = !tx_q;
            default:   sda_low_c = 1'b0;        // read, bus released
        endcase
    end

    assign scl = active ? scl_c : scl_rest;
    assign sda_drive_low = active ? sda_low_c : sda_low_rest;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            active       <= 1'b0;
            div_cnt      <= '0;
            phase        <= 2'd0;
            scl_rest     <= 1'b1;
            sda_low_rest <= 1'b0;
        end else if (!active) begin
            if (cmd_valid) begin
                active  <= 1'b1;
                div_cnt <= '0;
                phase   <= 2'd0;
            end
        end else if (phase_end) begin
            div_cnt <= '0;
            phase   <= phase + 2'd1;
            if (phase == 2'd3) begin
                active       <= 1'b0;
                scl_rest     <= scl_c;
                sda_low_rest <= sda_low_c;
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (!active && cmd_valid) begin
            cmd_q <= cmd;
            tx_q  <= tx_bit;
        end
        if (active && (phase == 2'd1) && phase_end)
            rx_bit <= sda_in;   // middle of scl high
    end

endmodule

`default_nettype wire

//--- hw/eeprom_seq.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_seq (
    input  wire logic                 CLK,
    input  wire logic                 RESET,
    input  wire logic                 start_wr,
    input  wire logic                 start_rd,
    input  wire eeprom_pkg::ee_addr_t ee_addr,
    input  wire eeprom_pkg::ee_data_t wr_data,
    output logic                      busy,
    output logic                      done,
    output logic                      nack,
    output eeprom_pkg::ee_data_t      rd_data,
    output eeprom_pkg::bit_cmd_t      cmd,
    output logic                      cmd_valid,
    output logic                      tx_bit,
    input  wire logic                 cmd_done,
    input  wire logic                 rx_bit
);
    import eeprom_pkg::*;

    seq_state_t state;
    ee_data_t   sh;          // byte being sent or received
    logic [3:0] bit_cnt;     // 0..7 data bits, 8 is the ack slot
    logic       rd_op;
    ee_addr_t   addr_q;
    ee_data_t   data_q;
    bit_cmd_t   cmd_c;
    logic       tx_c;
    logic       ack_phase;

    assign ack_phase = (bit_cnt == 4'd8);

    always_comb begin
        tx_c = sh[7];   // MSB first
        case (state)
            START, RESTART: cmd_c = CMD_START;
            CTRL_W, ADDR, DATA_W, CTRL_R: cmd_c = ack_phase ? CMD_READ : CMD_WRITE;
            DATA_R: begin
                cmd_c = ack_phase ? CMD_WRITE : CMD_READ;
                tx_c  = 1'b1;   // master NACK ends the read
            end
            default: cmd_c = CMD_STOP;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state     <= IDLE;
            bit_cnt   <= '0;
            rd_op     <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
            nack      <= 1'b0;
            cmd_valid <= 1'b0;
            cmd       <= CMD_STOP;
            tx_bit    <= 1'b1;
        end else begin
            done <= 1'b0;
            if (state == IDLE) begin
                if (start_wr || start_rd) begin
                    state  <= START;
                    busy   <= 1'b1;
                    nack   <= 1'b0;
                    rd_op  <= start_rd;
                    addr_q <= ee_addr;
                    data_q <= wr_data;
                end
            end else if (!cmd_valid) begin
                cmd_valid <= 1'b1;   // next command, one cycle after cmd_done
                cmd       <= cmd_c;
                tx_bit    <= tx_c;
            end else if (cmd_done) begin
                cmd_valid <= 1'b0;
                bit_cnt   <= bit_cnt + 4'd1;
                if (!ack_phase)
                    sh <= {sh[6:0], rx_bit};
                case (state)
                    START: begin
                        state   <= CTRL_W;
                        sh      <= {DEV_TYPE, addr_q[10:8], 1'b0};
                        bit_cnt <= '0;
                    end
                    RESTART: begin
                        state   <= CTRL_R;
                        sh      <= {DEV_TYPE, addr_q[10:8], 1'b1};
                        bit_cnt <= '0;
                    end
                    CTRL_W, ADDR, DATA_W, CTRL_R: begin
                        if (ack_phase) begin
                            bit_cnt <= '0;
                            if (rx_bit) begin
                                nack  <= 1'b1;   // no ack from the slave
                                state <= STOP;
                            end else if (state == CTRL_W) begin
                                state <= ADDR;
                                sh    <= addr_q[7:0];
                            end else if (state == ADDR) begin
                                state <= rd_op ? RESTART : DATA_W;
                                sh    <= data_q;
                            end else if (state == CTRL_R) begin
                                state <= DATA_R;
                            end else begin
                                state <= STOP;
                            end
                        end
                    end
                    DATA_R: begin
                        if (ack_phase) begin
                            bit_cnt <= '0;
                            rd_data <= sh;
                            state   <= STOP;
                        end
                    end
                    default: begin
                        state <= IDLE;   // stop sent
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/eeprom_regs.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_regs (
    input  wire logic                  CLK,
    input  wire logic                  RESET,
    input  wire logic                  psel,
    input  wire logic                  penable,
    input  wire logic                  pwrite,
    input  wire eeprom_pkg::apb_addr_t paddr,
    input  wire eeprom_pkg::apb_data_t pwdata,
    output eeprom_pkg::apb_data_t      prdata,
    output logic                       irq,
    output logic                       start_wr,
    output logic                       start_rd,
    output eeprom_pkg::ee_addr_t       ee_addr,
    output eeprom_pkg::ee_data_t       wr_data,
    input  wire logic                  busy,
    input  wire logic                  done,
    input  wire logic                  nack,
    input  wire eeprom_pkg::ee_data_t  rd_data
);
    import eeprom_pkg::*;

    logic     wr_en;
    logic     start_ok;
    logic     done_q;
    logic     nack_q;
    ee_data_t rdata_q;

    assign wr_en = psel && penable && pwrite;
    assign start_ok = wr_en && (paddr == REG_CTRL) && !busy;
    assign irq = done_q;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            start_wr <= 1'b0;
            start_rd <= 1'b0;
            done_q   <= 1'b0;
            nack_q   <= 1'b0;
        end else begin
            start_wr <= start_ok && pwdata[0];
            start_rd <= start_ok && pwdata[1] && !pwdata[0];   // write wins
            if (wr_en && (paddr == REG_STATUS)) begin
                if (pwdata[1])
                    done_q <= 1'b0;
                if (pwdata[2])
                    nack_q <= 1'b0;
            end
            // a new completion beats a clear in the same cycle
            if (done) begin
                done_q <= 1'b1;
                if (nack)
                    nack_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (wr_en && (paddr == REG_ADDR))
            ee_addr <= pwdata[10:0];
        if (wr_en && (paddr == REG_WDATA))
            wr_data <= pwdata[7:0];
        if (done)
            rdata_q <= rd_data;
    end

    always_comb begin
        case (paddr)
            REG_ADDR:   prdata = {21'b0, ee_addr};
            REG_WDATA:  prdata = {24'b0, wr_data};
            REG_STATUS: prdata = {29'b0, nack_q, done_q, busy};
            REG_RDATA:  prdata = {24'b0, rdata_q};
            default:    prdata = '0;   // ctrl reads back zero
        endcase
    end

endmodule

`default_nettype wire

//--- hw/eeprom_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_top (
    input  wire logic                  CLK,
    input  wire logic                  RESET,
    input  wire logic                  psel,
    input  wire logic                  penable,
    input  wire logic                  pwrite,
    input  wire eeprom_pkg::apb_addr_t paddr,
    input  wire eeprom_pkg::apb_data_t pwdata,
    output wire eeprom_pkg::apb_data_t prdata,
    output wire logic                  irq,
    output wire logic                  scl,
    output wire logic                  sda_drive_low,
    input  wire logic                  sda_in
);
    import eeprom_pkg::*;

    wire logic     start_wr;
    wire logic     start_rd;
    wire ee_addr_t ee_addr;
    wire ee_data_t wr_data;
    wire logic     busy;
    wire logic     done;
    wire logic     nack;
    wire ee_data_t rd_data;
    wire bit_cmd_t cmd;
    wire logic     cmd_valid;
    wire logic     tx_bit;
    wire logic     cmd_done;
    wire logic     rx_bit;

    eeprom_regs u_regs (.*);

    eeprom_seq u_seq (.*);

    i2c_bit_ctrl u_bit (.*);

endmodule

`default_nettype wire

//--- verif/eeprom_model.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_model (
    input  wire logic scl,
    input  wire logic sda,
    input  wire logic force_nack,
    output logic      sda_low,
    output int        txn_count
);
    typedef enum logic [2:0] {M_IDLE, M_CTRL, M_WORD, M_DATA, M_SEND} model_state_t;

    logic [7:0]   mem [0:2047];
    model_state_t state = M_IDLE;
    logic [7:0]   sh = '0;
    int           bit_cnt = 0;
    logic         ack_slot = 1'b0;   // slave ack clock in progress
    logic [10:0]  ptr = '0;
    logic         scl_q = 1'b1;
    logic         sda_q = 1'b1;

    initial begin
        sda_low   = 1'b0;
        txn_count = 0;
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hFF;   // erased part
    end

    // called on the falling edge after the eighth bit of a received byte
    task take_byte;
        sda_low  = 1'b1;
        ack_slot = 1'b1;
        case (state)
            M_CTRL: begin
                if (sh[7:4] != 4'b1010 || force_nack) begin
                    sda_low  = 1'b0;   // no ack, wait for stop
                    ack_slot = 1'b0;
                    state    = M_IDLE;
                end else begin
                    ptr[10:8] = sh[3:1];   // page bits
                    state     = sh[0] ? M_SEND : M_WORD;
                end
            end
            M_WORD: begin
                ptr[7:0] = sh;
                state    = M_DATA;
            end
            default: begin
                mem[ptr] = sh;
                state    = M_IDLE;   // single byte writes only
            end
        endcase
    endtask

    always @(scl or sda) begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda === 1'b0) begin
            state    = M_CTRL;   // start or repeated start
            bit_cnt  = 0;
            ack_slot = 1'b0;
            sda_low  = 1'b0;
        end else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda === 1'b1) begin
            state     = M_IDLE;   // stop
            sda_low   = 1'b0;
            txn_count = txn_count + 1;
        end else if (scl === 1'b1 && scl_q === 1'b0 && !ack_slot) begin
            if (state == M_SEND && bit_cnt == 8) begin
                state = M_IDLE;   // master ack slot ends the read
            end else if (state != M_IDLE && bit_cnt < 8) begin
                if (state != M_SEND)
                    sh = {sh[6:0], sda};
                bit_cnt = bit_cnt + 1;
            end
        end else if (scl === 1'b0 && scl_q === 1'b1) begin
            if (ack_slot) begin
                ack_slot = 1'b0;
                bit_cnt  = 0;
                sda_low  = 1'b0;
                if (state == M_SEND) begin
                    sh      = mem[ptr];
                    sda_low = !sh[7];   // msb first
                end
            end else if (state == M_SEND) begin
                sh      = sh << 1;
                sda_low = (bit_cnt < 8) ? !sh[7] : 1'b0;
            end else if (state != M_IDLE && bit_cnt == 8) begin
                take_byte();
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

`default_nettype wire

//--- verif/tb_eeprom_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_ctrl;
    import eeprom_pkg::*;

    localparam int NUM_OPS = 11;
    // one bit command plus two cycles of cmd_valid handshake
    localparam int CMD_CYCLES = 4 * SCL_PHASE_CYCLES + 2;
    // 40 commands and some APB traffic per entry, 8 ns period, 20 % margin
    localparam int WATCHDOG_NS = (10 + NUM_OPS * (40 * CMD_CYCLES + 100)) * 8 * 12 / 10;

    typedef struct packed {
        logic     is_read;
        ee_addr_t addr;
        ee_data_t data;
        logic     force_nack;
        ee_data_t exp_rdata;
        logic     exp_nack;
    } op_t;

    logic           CLK;
    logic           RESET;
    logic           psel;
    logic           penable;
    logic           pwrite;
    apb_addr_t      paddr;
    apb_data_t      pwdata;
    wire apb_data_t prdata;
    wire logic      irq;
    wire logic      scl;
    wire logic      sda_drive_low;
    wire logic      model_sda_low;
    wire logic      sda;
    logic           force_nack;
    int             txn_count;

    ee_data_t    shadow [0:2047];
    op_t         ops [NUM_OPS];
    op_t         op;
    int          n_ops;
    int          txn_before;
    int unsigned seed;
    apb_data_t   rd;
    ee_data_t    d0;
    ee_data_t    d1;

    assign sda = !(sda_drive_low || model_sda_low);   // wired-AND with pull-up

    eeprom_ctrl_top UUT (.*, .sda_in(sda));

    eeprom_model u_model (.*, .sda_low(model_sda_low));

    always #4 CLK = ~CLK;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        @(posedge CLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge CLK);
        penable <= 1'b1;
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
        @(posedge CLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge CLK);
        penable <= 1'b1;
        @(negedge CLK);
        data = prdata;   // mid access phase
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic wait_irq;
        @(negedge CLK);
        while (irq !== 1'b1)
            @(negedge CLK);
    endtask

    // expected values follow the shadow copy of the memory
    task automatic add_entry(input logic is_read, input ee_addr_t addr,
                             input ee_data_t data, input logic no_ack);
        op_t e;
        e.is_read    = is_read;
        e.addr       = addr;
        e.data       = data;
        e.force_nack = no_ack;
        e.exp_nack   = no_ack;
        e.exp_rdata  = shadow[addr];
        if (!is_read && !no_ack)
            shadow[addr] = data;
        ops[n_ops] = e;
        n_ops++;
    endtask

    initial begin
        CLK        = 1'b0;
        RESET      = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        force_nack = 1'b0;
        n_ops      = 0;
        seed       = 32'h6a3f_2982;
        d0         = 8'($urandom(seed));
        d1         = 8'($urandom());
        for (int i = 0; i < 2048; i++)
            shadow[i] = 8'hFF;

        add_entry(1'b0, 11'h123, d0, 1'b0);
        add_entry(1'b1, 11'h123, 8'h00, 1'b0);
        add_entry(1'b0, 11'h523, d1, 1'b0);    // same low byte, other page
        add_entry(1'b1, 11'h523, 8'h00, 1'b0);
        add_entry(1'b1, 11'h123, 8'h00, 1'b0);
        add_entry(1'b1, 11'h7FF, 8'h00, 1'b0);  // never written
        add_entry(1'b0, 11'h2A5, 8'h3C, 1'b1);
        add_entry(1'b1, 11'h2A5, 8'h00, 1'b0);
        add_entry(1'b0, 11'h6B0, 8'h5A, 1'b0);
        add_entry(1'b1, 11'h6B0, 8'h00, 1'b0);
        add_entry(1'b1, 11'h6B0, 8'h00, 1'b1);

        repeat (10) @(posedge CLK);
        RESET <= 1'b0;
        @(negedge CLK);
        check_value("scl", scl, 1);
        check_value("sda_drive_low", sda_drive_low, 0);
        check_value("irq", irq, 0);
        apb_read(REG_STATUS, rd);
        check_value("status after reset", rd, 0);

        for (int i = 0; i < n_ops; i++) begin
            op = ops[i];
            @(posedge CLK);
            force_nack <= op.force_nack;
            apb_write(REG_ADDR, {21'b0, op.addr});
            apb_write(REG_WDATA, {24'b0, op.data});
            txn_before = txn_count;
            apb_write(REG_CTRL, op.is_read ? 32'h2 : 32'h1);
            apb_read(REG_STATUS, rd);
            check_value("status while busy", rd, 32'h1);
            apb_write(REG_CTRL, 32'h3);   // must be dropped
            wait_irq();
            apb_read(REG_STATUS, rd);
            check_value("status at irq", rd, op.exp_nack ? 32'h6 : 32'h2);
            if (op.is_read && !op.exp_nack) begin
                apb_read(REG_RDATA, rd);
                check_value("rdata", rd, {24'b0, op.exp_rdata});
            end
            apb_write(REG_STATUS, 32'h6);
            @(negedge CLK);
            check_value("irq after clear", irq, 0);
            apb_read(REG_STATUS, rd);
            check_value("status after clear", rd, 0);
            check_value("transactions seen by model", txn_count - txn_before, 1);
        end

        $display("Everything OK");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the transfers did not finish within %0d ns", WATCHDOG_NS);
        $display("Something failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

//--- all.f
hw/eeprom_pkg.sv
hw/i2c_bit_ctrl.sv
hw/eeprom_seq.sv
hw/eeprom_regs.sv
hw/eeprom_ctrl_top.sv
verif/eeprom_model.sv
verif/tb_eeprom_ctrl.sv

//--- Bender.yml
package:
  name: eeprom_ctrl

sources:
  - files:
      - hw/eeprom_pkg.sv
      - hw/i2c_bit_ctrl.sv
      - hw/eeprom_seq.sv
      - hw/eeprom_regs.sv
      - hw/eeprom_ctrl_top.sv
  - target: test
    files:
      - verif/eeprom_model.sv
      - verif/tb_eeprom_ctrl.sv
